//--- src.f
+incdir+.
microwordPkg.sv
dispatchPkg.sv
controlStore.sv
skipSelect.sv
dispatchUnit.sv
callStack.sv
microSequencer.sv
microSequencer_sva.sv
microSequencer_tb.sv

//--- microSequencer_tb.sv
// Sequencer testbench
// Loads a random microprogram under reset, drives random dispatch,
// skip and page-fail inputs, and checks every step against a
// reference model of the next-address rules and the call stack
`timescale 1ns/1ps
`include "ucode_cfg.svh"

module microSequencer_tb
   import microwordPkg::*;
   import dispatchPkg::*;
();

   // Program shaping per test
   localparam int ModeAny  = 0;
   localparam int ModeSkip = 1;
   localparam int ModeDisp = 2;
   localparam int ModeCall = 3;

   logic      clk;
   logic      reset;
   logic      clken;
   logic      loadEnable;
   uAddrT     loadAddress;
   microwordT loadData;
   logic      pageFail;
   dataWordT  dp;
   uAddrT     dispDiag;
   dromWordT  drom;
   acT        ac;
   dispCodeT  codes [7];
   skipGroupT skipIn [3];
   microwordT microword;
   uAddrT     microAddress;

   // Input values for the current step
   logic      pfV;
   dataWordT  dpV;
   uAddrT     diagV;
   dromWordT  dromV;
   acT        acV;
   dispCodeT  codeV [7];
   skipGroupT skipV [3];

   //////////////////////////////////////////////////
   // Reference model state
   //////////////////////////////////////////////////
   microwordT mem [4096];
   uAddrT     mStack [8];
   logic [2:0] mPtr;
   microwordT mWord;
   uAddrT     mAddr;
   int        depth;
   int        maxDepth;
   int        areadSeen [3];

   int testErrors;
   int totalErrors;
   int testsRun;
   int testsFailed;

   microSequencer microSequencer_inst (
      .clk(clk), .reset(reset), .clken(clken),
      .loadEnable(loadEnable), .loadAddress(loadAddress), .loadData(loadData),
      .pageFail(pageFail), .dp(dp), .dispDiag(dispDiag), .drom(drom), .ac(ac),
      .dispMul(codes[0]), .dispPf(codes[1]), .dispNi(codes[2]), .dispByte(codes[3]),
      .dispEa(codes[4]), .dispScad(codes[5]), .dispNorm(codes[6]),
      .skip10(skipIn[0]), .skip20(skipIn[1]), .skip40(skipIn[2]),
      .microword(microword), .microAddress(microAddress)
   );

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #4 clk = ~clk;
      end
   end

   // Cycle limit for the whole run
   initial
   begin
      repeat (200000) @(posedge clk);
      $display("timeout: simulation ran past its cycle limit");
      $display("SOME TESTS FAILED");
      $finish;
   end

   task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp)
      begin
         $display("error %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
         testErrors++;
      end
   endtask

   //////////////////////////////////////////////////
   // Next-address rules
   //////////////////////////////////////////////////
   function automatic uAddrT predictNext(microwordT w);
      uAddrT      disp;
      uAddrT      result;
      logic [3:0] sel;
      skipSelT    s;
      sel = w[`CROM_DISP_LSB +: 4];
      disp = '0;
      case (sel)
         DISP_DIAG:  disp = diagV;
         DISP_RET:   disp = mStack[mPtr - 3'd1];
         DISP_J:     disp = dromV[19:8];
         DISP_AREAD:
         begin
            // Operand fetch, plain J or J with AC in the low bits
            if (!dromV[21])
            begin
               disp = 12'o40 + dromV[7:4];
               areadSeen[0]++;
            end
            else if (dromV[20])
            begin
               disp = {dromV[19:12], acV};
               areadSeen[2]++;
            end
            else
            begin
               disp = dromV[19:8];
               areadSeen[1]++;
            end
         end
         DISP_MUL, DISP_PF, DISP_NI, DISP_BYTE, DISP_EA, DISP_SCAD, DISP_NORM:
            disp = {8'd0, codeV[sel - 4'd5]};
         DISP_DROMA: disp = {8'd0, dromV[7:4]};
         DISP_DROMB: disp = {8'd0, dromV[3:0]};
         DISP_DP:    disp = {8'd0, dpV[3:0]};
         default:    disp = '0;
      endcase
      result = w[11:0] | disp;
      // Groups 10, 20, 40
      for (int k = 0; k < 3; k++)
      begin
         s = w[`CROM_SKIP10_LSB + 3 * k +: 3];
         if (s != 3'd0 && skipV[k][s])
         begin
            result[3 + k] = 1'b1;
         end
      end
      if (pfV)
      begin
         result = '1;
      end
      return result;
   endfunction

   task automatic modelStep();
      uAddrT nextA;
      nextA = predictNext(mWord);
      if (mWord[`CROM_CALL_BIT])
      begin
         mStack[mPtr] = mAddr + 12'd1;
         mPtr++;
         depth++;
         if (depth > maxDepth)
         begin
            maxDepth = depth;
         end
      end
      else if (mWord[`CROM_DISP_LSB +: 4] == DISP_RET)
      begin
         mPtr--;
         if (depth > 0)
         begin
            depth--;
         end
      end
      mAddr = nextA;
      mWord = mem[nextA];
   endtask

   function automatic microwordT shapeWord(microwordT w, int mode);
      int r;
      r = $urandom % 10;
      case (mode)
         ModeSkip:
         begin
            w[`CROM_DISP_LSB +: 4] = DISP_NONE;
            w[`CROM_CALL_BIT] = 1'b0;
         end
         ModeDisp:
            w[`CROM_CALL_BIT] = 1'b0;
         ModeCall:
         begin
            // Mostly calls so the stack wraps
            w[`CROM_CALL_BIT] = (r < 5);
            w[`CROM_DISP_LSB +: 4] = (r >= 5 && r < 8) ? DISP_RET : DISP_NONE;
            if (r >= 5 && r < 8)
            begin
               // Return lands exactly on the call address plus one
               w[`CROM_J_LSB +: `UADDR_WIDTH] = '0;
               w[`CROM_SKIP10_LSB +: 3 * `CROM_SKIP_WIDTH] = '0;
            end
         end
         default:
            w = w;
      endcase
      return w;
   endfunction

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////
   task automatic resetAndLoad(input int mode);
      logic [63:0] r;
      microwordT   w;
      @(posedge clk);
      reset <= 1'b1;
      clken <= 1'b0;
      for (int a = 0; a < 4096; a++)
      begin
         r = {$urandom, $urandom};
         w = shapeWord(r[47:0], mode);
         mem[a] = w;
         @(posedge clk);
         loadEnable  <= 1'b1;
         loadAddress <= uAddrT'(a);
         loadData    <= w;
      end
      @(posedge clk);
      loadEnable <= 1'b0;
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      for (int i = 0; i < 8; i++)
      begin
         mStack[i] = '0;
      end
      mPtr  = '0;
      mWord = '0;
      mAddr = '0;
      depth = 0;
      @(negedge clk);
   endtask

   task automatic randomizeInputs(input int pfPercent);
      logic [63:0] r;
      logic [31:0] s;
      r = {$urandom, $urandom};
      dpV   = r[35:0];
      diagV = r[47:36];
      acV   = r[51:48];
      r = {$urandom, $urandom};
      dromV = r[21:0];
      for (int k = 0; k < 7; k++)
      begin
         codeV[k] = r[22 + 4 * k +: 4];
      end
      s = $urandom;
      for (int k = 0; k < 3; k++)
      begin
         skipV[k] = s[8 * k +: 8];
      end
      pfV = ($urandom % 100) < pfPercent;
   endtask

   // Drive on one edge, step on the next, check at the falling edge
   task automatic advance(input logic en);
      @(posedge clk);
      clken    <= en;
      pageFail <= pfV;
      dp       <= dpV;
      dispDiag <= diagV;
      drom     <= dromV;
      ac       <= acV;
      for (int k = 0; k < 7; k++)
      begin
         codes[k] <= codeV[k];
      end
      for (int k = 0; k < 3; k++)
      begin
         skipIn[k] <= skipV[k];
      end
      if (en)
      begin
         modelStep();
      end
      @(posedge clk);
      clken <= 1'b0;
      @(negedge clk);
      compare("microAddress", microAddress, mAddr);
      compare("microword", microword, mWord);
   endtask

   task automatic runSteps(input int n, input int pfPercent, input int enPercent);
      for (int i = 0; i < n; i++)
      begin
         randomizeInputs(pfPercent);
         advance(($urandom % 100) < enPercent);
      end
   endtask

   task automatic finishTest(input string name);
      testsRun++;
      totalErrors += testErrors;
      if (testErrors != 0)
      begin
         testsFailed++;
      end
      $display("test %s %s (%0d errors)", name, testErrors == 0 ? "ok" : "bad", testErrors);
      testErrors = 0;
   endtask

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////
   initial
   begin
      void'($urandom(5386));
      testErrors  = 0;
      totalErrors = 0;
      testsRun    = 0;
      testsFailed = 0;
      reset <= 1'b1;
      clken <= 1'b0;
      loadEnable <= 1'b0;
      loadAddress <= '0;
      loadData <= '0;
      pageFail <= 1'b0;
      dp <= '0;
      dispDiag <= '0;
      drom <= '0;
      ac <= '0;
      for (int k = 0; k < 7; k++)
      begin
         codes[k] <= '0;
      end
      for (int k = 0; k < 3; k++)
      begin
         skipIn[k] <= '0;
      end

      // Reset state and first fetch from address 0
      resetAndLoad(ModeAny);
      compare("microword", microword, 48'd0);
      compare("microAddress", microAddress, 12'd0);
      randomizeInputs(0);
      advance(1'b1);
      compare("microAddress", microAddress, 12'd0);
      runSteps(20, 0, 100);
      finishTest("reset");

      resetAndLoad(ModeSkip);
      runSteps(300, 0, 100);
      finishTest("skip");

      resetAndLoad(ModeDisp);
      for (int k = 0; k < 3; k++)
      begin
         areadSeen[k] = 0;
      end
      runSteps(600, 0, 100);
      for (int k = 0; k < 3; k++)
      begin
         if (areadSeen[k] == 0)
         begin
            $display("AREAD case %0d was never exercised", k);
            testErrors++;
         end
      end
      finishTest("dispatch");

      resetAndLoad(ModeCall);
      maxDepth = 0;
      runSteps(300, 0, 100);
      if (maxDepth <= 8)
      begin
         $display("call depth never went past eight entries");
         testErrors++;
      end
      finishTest("callstack");

      resetAndLoad(ModeAny);
      runSteps(300, 50, 100);
      finishTest("pagefail");

      // Idle gaps with live inputs
      resetAndLoad(ModeAny);
      runSteps(400, 10, 60);
      finishTest("hold");

      $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, totalErrors);
      if (testsFailed == 0)
      begin
         $display("ALL TESTS PASSED");
      end
      else
      begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- microSequencer_sva.sv
// Sequencer assertions
// Bound to the sequencer top level. Covers reset clearing,
// the page-fail trap and holding while clken is low
`timescale 1ns/1ps

module microSequencer_sva
   import microwordPkg::*;
(
   input logic      clk,
   input logic      reset,
   input logic      clken,
   input logic      pageFail,
   input microwordT microword,
   input uAddrT     microAddress
);

   // Zero word and address one edge after reset
   property resetClears;
      @(posedge clk) reset |=> (microword == '0 && microAddress == '0);
   endproperty

   // Trap location is all ones
   property pageFailTraps;
      @(posedge clk) disable iff (reset)
         (clken && pageFail) |=> (microAddress == '1);
   endproperty

   // No advance without clken
   property holdWhenIdle;
      @(posedge clk) disable iff (reset)
         !clken |=> ($stable(microAddress) && $stable(microword));
   endproperty

   assert property (resetClears)
      else $error("microword or microAddress not cleared after reset");
   assert property (pageFailTraps)
      else $error("page fail did not trap to the all-ones address");
   assert property (holdWhenIdle)
      else $error("outputs changed while clken was low");

endmodule

bind microSequencer microSequencer_sva microSequencer_sva_inst (.*);

//--- microSequencer.sv
// Microprogram sequencer
// Fetches one microword per enabled clock from the writable control
// store and forms the next address from the jump field, dispatch,
// three skip groups, the call stack and page fail
`timescale 1ns/1ps
`include "ucode_cfg.svh"

module microSequencer
   import microwordPkg::*;
   import dispatchPkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      clken,
   // Control store load port
   input  logic      loadEnable,
   input  uAddrT     loadAddress,
   input  microwordT loadData,
   // Trap request
   input  logic      pageFail,
   // Dispatch sources
   input  dataWordT  dp,
   input  uAddrT     dispDiag,
   input  dromWordT  drom,
   input  acT        ac,
   input  dispCodeT  dispMul,
   input  dispCodeT  dispPf,
   input  dispCodeT  dispNi,
   input  dispCodeT  dispByte,
   input  dispCodeT  dispEa,
   input  dispCodeT  dispScad,
   input  dispCodeT  dispNorm,
   // Skip condition groups
   input  skipGroupT skip10,
   input  skipGroupT skip20,
   input  skipGroupT skip40,
   output microwordT microword,
   output uAddrT     microAddress
);

   uAddrT      nextAddress;
   uAddrT      returnAddress;
   logic [2:0] skipHits;
   skipGroupT  skipGroups [3];

   // Group order follows the generate index
   assign skipGroups[0] = skip10;
   assign skipGroups[1] = skip20;
   assign skipGroups[2] = skip40;

   //////////////////////////////////////////////////
   // Control store
   //////////////////////////////////////////////////
   controlStore controlStore_inst (
      .clk          (clk),
      .reset        (reset),
      .clken        (clken),
      .loadEnable   (loadEnable),
      .loadAddress  (loadAddress),
      .loadData     (loadData),
      .nextAddress  (nextAddress),
      .microword    (microword),
      .microAddress (microAddress)
   );

   // Skip fields sit side by side from group 10 upward
   for (genvar k = 0; k < 3; k++)
   begin : genSkip
      skipSelect skipSelect_inst (
         .select     (microword[`CROM_SKIP10_LSB + `CROM_SKIP_WIDTH * k +: `CROM_SKIP_WIDTH]),
         .conditions (skipGroups[k]),
         .hit        (skipHits[k])
      );
   end

   //////////////////////////////////////////////////
   // Next address
   //////////////////////////////////////////////////
   dispatchUnit dispatchUnit_inst (
      .microword     (microword),
      .dp            (dp),
      .dispDiag      (dispDiag),
      .returnAddress (returnAddress),
      .drom          (drom),
      .ac            (ac),
      .dispMul       (dispMul),
      .dispPf        (dispPf),
      .dispNi        (dispNi),
      .dispByte      (dispByte),
      .dispEa        (dispEa),
      .dispScad      (dispScad),
      .dispNorm      (dispNorm),
      .skipHits      (skipHits),
      .pageFail      (pageFail),
      .nextAddress   (nextAddress)
   );

   // Return addresses for the RET dispatch
   callStack callStack_inst (
      .clk           (clk),
      .reset         (reset),
      .clken         (clken),
      .microword     (microword),
      .microAddress  (microAddress),
      .returnAddress (returnAddress)
   );

endmodule

//--- callStack.sv
// Call stack
// Eight-entry circular return-address stack. A call pushes the
// address after the calling microword and a return dispatch pops
`timescale 1ns/1ps
`include "ucode_cfg.svh"

module callStack
   import microwordPkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      clken,
   input  microwordT microword,
   input  uAddrT     microAddress,
   output uAddrT     returnAddress
);

   localparam int PtrWidth = $clog2(`STACK_DEPTH);

   uAddrT               stack [0:`STACK_DEPTH-1];
   // Next free slot
   logic [PtrWidth-1:0] ptr;
   // Most recent entry, wraps below zero
   logic [PtrWidth-1:0] topPtr;
   logic                call;
   logic                ret;

   // Push and pop decoded from the current microword
   assign call = microword[`CROM_CALL_BIT];
   assign ret  = dispSelT'(microword[`CROM_DISP_LSB +: `CROM_DISP_WIDTH]) == DISP_RET;

   assign topPtr        = ptr - 1'b1;
   assign returnAddress = stack[topPtr];

   //////////////////////////////////////////////////
   // Stack update
   //////////////////////////////////////////////////
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         // Empty stack returns address 0 after reset
         ptr <= '0;
         for (int i = 0; i < `STACK_DEPTH; i++)
         begin
            stack[i] <= '0;
         end
      end
      else if (clken)
      begin
         // Call wins over a return in the same word
         if (call)
         begin
            // Ninth push overwrites the oldest entry
            stack[ptr] <= microAddress + 1'b1;
            ptr        <= ptr + 1'b1;
         end
         else if (ret)
         begin
            ptr <= topPtr;
         end
      end
   end

endmodule

//--- dispatchUnit.sv
// Dispatch unit
// Decodes the AREAD dispatch from the dispatch ROM word, selects
// the dispatch source named by the microword and ORs it with the
// jump field and skip bits. Page fail forces the trap address
`timescale 1ns/1ps
`include "ucode_cfg.svh"

module dispatchUnit
   import microwordPkg::*;
   import dispatchPkg::*;
(
   input  microwordT  microword,
   input  dataWordT   dp,
   input  uAddrT      dispDiag,
   input  uAddrT      returnAddress,
   input  dromWordT   drom,
   input  acT         ac,
   input  dispCodeT   dispMul,
   input  dispCodeT   dispPf,
   input  dispCodeT   dispNi,
   input  dispCodeT   dispByte,
   input  dispCodeT   dispEa,
   input  dispCodeT   dispScad,
   input  dispCodeT   dispNorm,
   // Hit k lands on address bit 3+k
   input  logic [2:0] skipHits,
   input  logic       pageFail,
   output uAddrT      nextAddress
);

   // Microword fields
   uAddrT    jump;
   dispSelT  dispSel;
   // Dispatch ROM fields
   logic     dromAeqJ;
   logic     dromAcDisp;
   uAddrT    dromJ;
   dispCodeT dromA;
   dispCodeT dromB;
   // Address terms
   uAddrT    dispAread;
   uAddrT    dispAddress;
   uAddrT    skipAddress;

   assign jump    = microword[`CROM_J_LSB +: `UADDR_WIDTH];
   assign dispSel = dispSelT'(microword[`CROM_DISP_LSB +: `CROM_DISP_WIDTH]);

   assign dromAeqJ   = drom[`DROM_AEQJ_BIT];
   assign dromAcDisp = drom[`DROM_ACDISP_BIT];
   assign dromJ      = drom[`DROM_J_LSB +: `UADDR_WIDTH];
   assign dromA      = drom[`DROM_A_LSB +: $bits(dispCodeT)];
   assign dromB      = drom[`DROM_B_LSB +: $bits(dispCodeT)];

   //////////////////////////////////////////////////
   // AREAD decode
   //////////////////////////////////////////////////
   always_comb
   begin
      if (!dromAeqJ)
      begin
         // Operand fetch routines at 40 to 57
         dispAread = 12'o0040 | uAddrT'(dromA);
      end
      else if (dromAcDisp)
      begin
         // AC expands the opcode to 16 entry points
         dispAread = {dromJ[`UADDR_WIDTH-1:4], ac};
      end
      else
      begin
         // Immediate execute without operand fetch
         dispAread = dromJ;
      end
   end

   //////////////////////////////////////////////////
   // Dispatch mux
   //////////////////////////////////////////////////
   always_comb
   begin
      case (dispSel)
         DISP_DIAG:  dispAddress = dispDiag;
         DISP_RET:   dispAddress = returnAddress;
         DISP_J:     dispAddress = dromJ;
         DISP_AREAD: dispAddress = dispAread;
         // Narrow dispatches fill the low four bits
         DISP_MUL:   dispAddress = uAddrT'(dispMul);
         DISP_PF:    dispAddress = uAddrT'(dispPf);
         DISP_NI:    dispAddress = uAddrT'(dispNi);
         DISP_BYTE:  dispAddress = uAddrT'(dispByte);
         DISP_EA:    dispAddress = uAddrT'(dispEa);
         DISP_SCAD:  dispAddress = uAddrT'(dispScad);
         DISP_NORM:  dispAddress = uAddrT'(dispNorm);
         DISP_DROMA: dispAddress = uAddrT'(dromA);
         DISP_DROMB: dispAddress = uAddrT'(dromB);
         DISP_DP:    dispAddress = uAddrT'(dp[3:0]);
         default:    dispAddress = '0;
      endcase
   end

   // Skip groups 10, 20 and 40
   assign skipAddress = uAddrT'({skipHits, 3'b000});

   // Trap to 7777 overrides everything
   assign nextAddress = pageFail ? '1 : (jump | dispAddress | skipAddress);

endmodule

//--- skipSelect.sv
// Skip selector
// Tests one condition of a skip group under the microword's
// 3-bit skip field. Select zero never skips
`timescale 1ns/1ps

module skipSelect
   import microwordPkg::*;
   import dispatchPkg::*;
(
   input  skipSelT   select,
   input  skipGroupT conditions,
   output logic      hit
);

   // 8:1 mux with input 0 tied low
   always_comb
   begin
      case (select)
         3'd1:
         begin
            hit = conditions[1];
         end
         3'd2:
         begin
            hit = conditions[2];
         end
         3'd3:
         begin
            hit = conditions[3];
         end
         3'd4:
         begin
            hit = conditions[4];
         end
         3'd5:
         begin
            hit = conditions[5];
         end
         3'd6:
         begin
            hit = conditions[6];
         end
         3'd7:
         begin
            hit = conditions[7];
         end
         // No skip
         default:
         begin
            hit = 1'b0;
         end
      endcase
   end

endmodule

//--- controlStore.sv
// Writable control store
// 4096 microwords with a load port and a registered fetch.
// Holds the current microword and the address it came from
`timescale 1ns/1ps
`include "ucode_cfg.svh"

module controlStore
   import microwordPkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      clken,
   // Load port ignores clken
   input  logic      loadEnable,
   input  uAddrT     loadAddress,
   input  microwordT loadData,
   // Fetch address from the dispatch unit
   input  uAddrT     nextAddress,
   output microwordT microword,
   output uAddrT     microAddress
);

   localparam int Depth = 1 << `UADDR_WIDTH;

   // Microcode RAM
   microwordT store [0:Depth-1];

   //////////////////////////////////////////////////
   // Write port
   //////////////////////////////////////////////////
   always_ff @(posedge clk)
   begin
      if (loadEnable)
      begin
         store[loadAddress] <= loadData;
      end
   end

   //////////////////////////////////////////////////
   // Fetch
   //////////////////////////////////////////////////
   // One microword per enabled edge
   // Read register doubles as the microinstruction register
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         // Zero word selects no dispatch, skip or call
         microword    <= '0;
         microAddress <= '0;
      end
      else if (clken)
      begin
         microword    <= store[nextAddress];
         microAddress <= nextAddress;
      end
   end

endmodule

//--- dispatchPkg.sv
// Dispatch package
// Types for the datapath word, the dispatch ROM word,
// the narrow dispatch codes and the skip condition groups
`include "ucode_cfg.svh"

package dispatchPkg;

   // Datapath word
   typedef logic [`DP_WIDTH-1:0] dataWordT;

   // Four-bit code from the datapath dispatch decoders
   typedef logic [3:0] dispCodeT;

   //////////////////////////////////////////////////
   // Dispatch ROM word
   //////////////////////////////////////////////////
   // Bit 21     AEQJ (AREAD goes straight to J)
   // Bit 20     ACDISP (AC replaces low four bits of J)
   // Bits 19:8  J
   // Bits 7:4   A
   // Bits 3:0   B
   typedef logic [`DROM_WIDTH-1:0] dromWordT;

   // Eight conditions tested by one skip group
   // Condition 0 is never selected
   typedef logic [7:0] skipGroupT;

   // Accumulator number from the instruction word
   typedef logic [3:0] acT;

endpackage

//--- microwordPkg.sv
// Microword package
// Types for microaddresses, microwords and the sequencer
// control fields carried in each microword
`include "ucode_cfg.svh"

package microwordPkg;

   // Control store address
   typedef logic [`UADDR_WIDTH-1:0] uAddrT;

   // Full microword with jump, dispatch, skip and call fields
   typedef logic [`CROM_WIDTH-1:0] microwordT;

   //////////////////////////////////////////////////
   // Dispatch select field
   //////////////////////////////////////////////////
   // Picks the source ORed into the next address
   typedef enum logic [`CROM_DISP_WIDTH-1:0] {
      DISP_NONE  = 4'd0,
      DISP_DIAG  = 4'd1,
      DISP_RET   = 4'd2,
      DISP_J     = 4'd3,
      DISP_AREAD = 4'd4,
      DISP_MUL   = 4'd5,
      DISP_PF    = 4'd6,
      DISP_NI    = 4'd7,
      DISP_BYTE  = 4'd8,
      DISP_EA    = 4'd9,
      DISP_SCAD  = 4'd10,
      DISP_NORM  = 4'd11,
      DISP_DROMA = 4'd12,
      DISP_DROMB = 4'd13,
      DISP_DP    = 4'd14    // low datapath bits
   } dispSelT;

   // Code 15 is spare and dispatches to zero

   // Condition index within one skip group
   typedef logic [`CROM_SKIP_WIDTH-1:0] skipSelT;

endpackage

//--- ucode_cfg.svh
// Microcode sequencer configuration
// Control store geometry, microword field positions,
// dispatch ROM layout and call stack depth
`ifndef UCODE_CFG_SVH
`define UCODE_CFG_SVH

//////////////////////////////////////////////////
// Control store
//////////////////////////////////////////////////
`define UADDR_WIDTH      12
`define CROM_WIDTH       48

// Microword field positions
`define CROM_J_LSB       0
`define CROM_DISP_LSB    12
`define CROM_DISP_WIDTH  4
`define CROM_SKIP10_LSB  16
`define CROM_SKIP20_LSB  19
`define CROM_SKIP40_LSB  22
`define CROM_SKIP_WIDTH  3
`define CROM_CALL_BIT    25
// Bits 26 to 47 carry opaque datapath controls

//////////////////////////////////////////////////
// Dispatch ROM and datapath
//////////////////////////////////////////////////
`define DROM_WIDTH       22
`define DROM_AEQJ_BIT    21
`define DROM_ACDISP_BIT  20
`define DROM_J_LSB       8
`define DROM_A_LSB       4
`define DROM_B_LSB       0
`define DP_WIDTH         36

// Call stack depth must be a power of two
`define STACK_DEPTH      8

`endif
